// File: logic/dma_ctrl_pkg.sv
`default_nettype none

package dma_ctrl_pkg;

    typedef logic [63:0] pcie_addr_t;
    typedef logic [31:0] local_addr_t;
    typedef logic [15:0] dma_len_t;
    typedef logic [7:0]  dma_tag_t;
    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // register map, byte addresses
    localparam reg_addr_t ADDR_ENABLE     = 16'h0000;

    localparam reg_addr_t ADDR_RD_PCIE_LO = 16'h0100;
    localparam reg_addr_t ADDR_RD_PCIE_HI = 16'h0104;
    localparam reg_addr_t ADDR_RD_LOCAL   = 16'h0108;
    localparam reg_addr_t ADDR_RD_LEN     = 16'h0110;
    localparam reg_addr_t ADDR_RD_TAG     = 16'h0114;
    localparam reg_addr_t ADDR_RD_STATUS  = 16'h0118;

    localparam reg_addr_t ADDR_WR_PCIE_LO = 16'h0200;
    localparam reg_addr_t ADDR_WR_PCIE_HI = 16'h0204;
    localparam reg_addr_t ADDR_WR_LOCAL   = 16'h0208;
    localparam reg_addr_t ADDR_WR_LEN     = 16'h0210;
    localparam reg_addr_t ADDR_WR_TAG     = 16'h0214;
    localparam reg_addr_t ADDR_WR_STATUS  = 16'h0218;

    localparam reg_addr_t ADDR_CNT_RQ     = 16'h0400;
    localparam reg_addr_t ADDR_CNT_RC     = 16'h0404;
    localparam reg_addr_t ADDR_CNT_CQ     = 16'h0408;
    localparam reg_addr_t ADDR_CNT_CC     = 16'h040C;

    // set in a status word while a completion is waiting
    localparam int unsigned STATUS_VALID_BIT = 31;

    typedef enum logic [4:0] {
        REG_NONE,
        REG_ENABLE,
        REG_RD_PCIE_LO,
        REG_RD_PCIE_HI,
        REG_RD_LOCAL,
        REG_RD_LEN,
        REG_RD_TAG,
        REG_RD_STATUS,
        REG_WR_PCIE_LO,
        REG_WR_PCIE_HI,
        REG_WR_LOCAL,
        REG_WR_LEN,
        REG_WR_TAG,
        REG_WR_STATUS,
        REG_CNT_RQ,
        REG_CNT_RC,
        REG_CNT_CQ,
        REG_CNT_CC
    } reg_sel_e;

    // host register request
    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        reg_data_t data;
    } reg_req_t;

    // decoded command, strobes high only in the accept cycle
    typedef struct packed {
        logic      wr_en;
        logic      rd_en;
        reg_sel_e  sel;
        reg_data_t data;
    } reg_cmd_t;

    typedef struct packed {
        pcie_addr_t  pcie_addr;
        local_addr_t local_addr;
        dma_len_t    len;
        dma_tag_t    tag;
    } dma_desc_t;

endpackage

`default_nettype wire

// File: logic/dma_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dma_reg_decode
    import dma_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  reg_req_t req,
    input  logic     req_valid,
    output logic     req_ready,

    input  logic     rsp_valid,

    output reg_cmd_t cmd
);

    reg_addr_t word_addr;
    reg_sel_e  sel;
    logic      accept;

    // one outstanding request at a time
    assign req_ready = !rsp_valid;
    assign accept    = req_valid && req_ready;

    // byte lanes are not used, registers are whole words
    assign word_addr = {req.addr[15:2], 2'b00};

    always_comb begin
        case (word_addr)
            ADDR_ENABLE:     sel = REG_ENABLE;
            ADDR_RD_PCIE_LO: sel = REG_RD_PCIE_LO;
            ADDR_RD_PCIE_HI: sel = REG_RD_PCIE_HI;
            ADDR_RD_LOCAL:   sel = REG_RD_LOCAL;
            ADDR_RD_LEN:     sel = REG_RD_LEN;
            ADDR_RD_TAG:     sel = REG_RD_TAG;
            ADDR_RD_STATUS:  sel = REG_RD_STATUS;
            ADDR_WR_PCIE_LO: sel = REG_WR_PCIE_LO;
            ADDR_WR_PCIE_HI: sel = REG_WR_PCIE_HI;
            ADDR_WR_LOCAL:   sel = REG_WR_LOCAL;
            ADDR_WR_LEN:     sel = REG_WR_LEN;
            ADDR_WR_TAG:     sel = REG_WR_TAG;
            ADDR_WR_STATUS:  sel = REG_WR_STATUS;
            ADDR_CNT_RQ:     sel = REG_CNT_RQ;
            ADDR_CNT_RC:     sel = REG_CNT_RC;
            ADDR_CNT_CQ:     sel = REG_CNT_CQ;
            ADDR_CNT_CC:     sel = REG_CNT_CC;
            default:         sel = REG_NONE;
        endcase
    end

    always_comb begin
        cmd.wr_en = accept && req.wr;
        cmd.rd_en = accept && !req.wr;
        cmd.sel   = sel;
        cmd.data  = req.data;
    end

endmodule

`default_nettype wire

// File: logic/dma_desc_issue.sv
`timescale 1ns/1ps
`default_nettype none

module dma_desc_issue
    import dma_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  reg_cmd_t  cmd,

    output logic      dma_enable,

    output dma_desc_t rd_desc,
    output logic      rd_desc_valid,
    input  logic      rd_desc_ready,

    output dma_desc_t wr_desc,
    output logic      wr_desc_valid,
    input  logic      wr_desc_ready
);

    reg_sel_e  wr_sel;
    dma_desc_t rd_desc_next;
    dma_desc_t wr_desc_next;
    logic      rd_tag_wr;
    logic      wr_tag_wr;

    // applies one register write to a staged descriptor,
    // the five selects name that side's field registers
    function automatic dma_desc_t desc_update(
        input dma_desc_t cur,
        input reg_sel_e  sel,
        input reg_sel_e  sel_pcie_lo,
        input reg_sel_e  sel_pcie_hi,
        input reg_sel_e  sel_local,
        input reg_sel_e  sel_len,
        input reg_sel_e  sel_tag,
        input reg_data_t data
    );
        dma_desc_t nxt;
        nxt = cur;
        if (sel == sel_pcie_lo) begin
            nxt.pcie_addr[31:0] = data;
        end else if (sel == sel_pcie_hi) begin
            nxt.pcie_addr[63:32] = data;
        end else if (sel == sel_local) begin
            nxt.local_addr = data;
        end else if (sel == sel_len) begin
            nxt.len = data[15:0];
        end else if (sel == sel_tag) begin
            nxt.tag = data[7:0];
        end
        return nxt;
    endfunction

    // only writes touch the descriptors
    assign wr_sel = cmd.wr_en ? cmd.sel : REG_NONE;

    assign rd_tag_wr = (wr_sel == REG_RD_TAG);
    assign wr_tag_wr = (wr_sel == REG_WR_TAG);

    always_comb begin
        rd_desc_next = desc_update(rd_desc, wr_sel, REG_RD_PCIE_LO, REG_RD_PCIE_HI,
                                   REG_RD_LOCAL, REG_RD_LEN, REG_RD_TAG, cmd.data);
        wr_desc_next = desc_update(wr_desc, wr_sel, REG_WR_PCIE_LO, REG_WR_PCIE_HI,
                                   REG_WR_LOCAL, REG_WR_LEN, REG_WR_TAG, cmd.data);
    end

    always_ff @(posedge clk) begin
        rd_desc <= rd_desc_next;
        wr_desc <= wr_desc_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dma_enable    <= 1'b0;
            rd_desc_valid <= 1'b0;
            wr_desc_valid <= 1'b0;
        end else begin
            if (wr_sel == REG_ENABLE) begin
                dma_enable <= cmd.data[0];
            end

            // a new tag write wins over a handshake in the same cycle
            if (rd_tag_wr) begin
                rd_desc_valid <= 1'b1;
            end else if (rd_desc_ready) begin
                rd_desc_valid <= 1'b0;
            end

            if (wr_tag_wr) begin
                wr_desc_valid <= 1'b1;
            end else if (wr_desc_ready) begin
                wr_desc_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/dma_reg_readback.sv
`timescale 1ns/1ps
`default_nettype none

module dma_reg_readback
    import dma_ctrl_pkg::*;
#(
    parameter int unsigned COUNT_WIDTH = 32
)
(
    input  logic                        clk,
    input  logic                        rst,

    input  reg_cmd_t                    cmd,

    input  logic                        dma_enable,

    input  dma_tag_t                    rd_status_tag,
    input  logic                        rd_status_valid,
    output logic                        rd_status_ready,

    input  dma_tag_t                    wr_status_tag,
    input  logic                        wr_status_valid,
    output logic                        wr_status_ready,

    // index 0 RQ, 1 RC, 2 CQ, 3 CC
    input  logic [3:0][COUNT_WIDTH-1:0] counts,

    output reg_data_t                   rsp_data,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,

    output logic                        irq
);

    reg_data_t rd_data;
    reg_data_t rd_status_word;
    reg_data_t wr_status_word;

    assign irq = rd_status_valid || wr_status_valid;

    always_comb begin
        rd_status_word = reg_data_t'(rd_status_tag);
        rd_status_word[STATUS_VALID_BIT] = rd_status_valid;
        wr_status_word = reg_data_t'(wr_status_tag);
        wr_status_word[STATUS_VALID_BIT] = wr_status_valid;
    end

    // narrow counters come back zero-extended
    always_comb begin
        case (cmd.sel)
            REG_ENABLE:    rd_data = reg_data_t'(dma_enable);
            REG_RD_STATUS: rd_data = rd_status_word;
            REG_WR_STATUS: rd_data = wr_status_word;
            REG_CNT_RQ:    rd_data = reg_data_t'(counts[0]);
            REG_CNT_RC:    rd_data = reg_data_t'(counts[1]);
            REG_CNT_CQ:    rd_data = reg_data_t'(counts[2]);
            REG_CNT_CC:    rd_data = reg_data_t'(counts[3]);
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cmd.wr_en || cmd.rd_en) begin
            rsp_data <= cmd.rd_en ? rd_data : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid       <= 1'b0;
            rd_status_ready <= 1'b0;
            wr_status_ready <= 1'b0;
        end else begin
            if (cmd.wr_en || cmd.rd_en) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end

            // pop only what the host actually saw
            rd_status_ready <= cmd.rd_en && (cmd.sel == REG_RD_STATUS) && rd_status_valid;
            wr_status_ready <= cmd.rd_en && (cmd.sel == REG_WR_STATUS) && wr_status_valid;
        end
    end

endmodule

`default_nettype wire

// File: logic/pkt_counters.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_counters #(
    parameter int unsigned COUNT_WIDTH = 32
)
(
    input  logic                        clk,
    input  logic                        rst,

    // bit 0 RQ, 1 RC, 2 CQ, 3 CC
    input  logic [3:0]                  pkt_done,

    output logic [3:0][COUNT_WIDTH-1:0] counts
);

    // free running, wraps at the top
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (pkt_done[i]) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/dma_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_top
    import dma_ctrl_pkg::*;
#(
    parameter int unsigned COUNT_WIDTH = 32
)
(
    input  logic      clk,
    input  logic      rst,

    // host register port
    input  reg_req_t  req,
    input  logic      req_valid,
    output logic      req_ready,
    output reg_data_t rsp_data,
    output logic      rsp_valid,
    input  logic      rsp_ready,

    output logic      dma_enable,

    output dma_desc_t rd_desc,
    output logic      rd_desc_valid,
    input  logic      rd_desc_ready,

    output dma_desc_t wr_desc,
    output logic      wr_desc_valid,
    input  logic      wr_desc_ready,

    // completion status from the engine
    input  dma_tag_t  rd_status_tag,
    input  logic      rd_status_valid,
    output logic      rd_status_ready,

    input  dma_tag_t  wr_status_tag,
    input  logic      wr_status_valid,
    output logic      wr_status_ready,

    input  logic [3:0] pkt_done,

    output logic      irq
);

    reg_cmd_t                    cmd;
    logic [3:0][COUNT_WIDTH-1:0] counts;

    dma_reg_decode i_decode (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .cmd       (cmd)
    );

    dma_desc_issue i_desc_issue (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd),
        .dma_enable    (dma_enable),
        .rd_desc       (rd_desc),
        .rd_desc_valid (rd_desc_valid),
        .rd_desc_ready (rd_desc_ready),
        .wr_desc       (wr_desc),
        .wr_desc_valid (wr_desc_valid),
        .wr_desc_ready (wr_desc_ready)
    );

    dma_reg_readback #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_readback (
        .clk             (clk),
        .rst             (rst),
        .cmd             (cmd),
        .dma_enable      (dma_enable),
        .rd_status_tag   (rd_status_tag),
        .rd_status_valid (rd_status_valid),
        .rd_status_ready (rd_status_ready),
        .wr_status_tag   (wr_status_tag),
        .wr_status_valid (wr_status_valid),
        .wr_status_ready (wr_status_ready),
        .counts          (counts),
        .rsp_data        (rsp_data),
        .rsp_valid       (rsp_valid),
        .rsp_ready       (rsp_ready),
        .irq             (irq)
    );

    pkt_counters #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_pkt_counters (
        .clk      (clk),
        .rst      (rst),
        .pkt_done (pkt_done),
        .counts   (counts)
    );

endmodule

`default_nettype wire

// File: dv/dma_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_tb
    import dma_ctrl_pkg::*;
();

    localparam int CLK_PERIOD     = 8;
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk = 1'b0;
    logic       rst;
    reg_req_t   req;
    logic       req_valid;
    logic       req_ready;
    reg_data_t  rsp_data;
    logic       rsp_valid;
    logic       rsp_ready;
    logic       dma_enable;
    dma_desc_t  rd_desc;
    logic       rd_desc_valid;
    logic       rd_desc_ready;
    dma_desc_t  wr_desc;
    logic       wr_desc_valid;
    logic       wr_desc_ready;
    dma_tag_t   rd_status_tag;
    logic       rd_status_valid;
    logic       rd_status_ready;
    dma_tag_t   wr_status_tag;
    logic       wr_status_valid;
    logic       wr_status_ready;
    logic [3:0] pkt_done;
    logic       irq;

    // register model
    logic             model_enable = 1'b0;
    logic [3:0][31:0] model_cnt = '0;
    reg_data_t        exp_q[$];
    reg_data_t        cmp_exp;

    int checks = 0;
    int errors = 0;
    int cmp_checks = 0;
    int cmp_errors = 0;
    int rd_issues = 0;
    int wr_issues = 0;
    int rd_pops = 0;
    int wr_pops = 0;

    dma_ctrl_top #(
        .COUNT_WIDTH (32)
    ) i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic reg_data_t expected_read(
        input logic             en,
        input logic             rs_valid,
        input dma_tag_t         rs_tag,
        input logic             ws_valid,
        input dma_tag_t         ws_tag,
        input logic [3:0][31:0] cnt,
        input reg_addr_t        addr
    );
        reg_data_t d;
        d = '0;
        case ({addr[15:2], 2'b00})
            ADDR_ENABLE:    d[0] = en;
            ADDR_RD_STATUS: d = {rs_valid, 23'd0, rs_tag};
            ADDR_WR_STATUS: d = {ws_valid, 23'd0, ws_tag};
            ADDR_CNT_RQ:    d = cnt[0];
            ADDR_CNT_RC:    d = cnt[1];
            ADDR_CNT_CQ:    d = cnt[2];
            ADDR_CNT_CC:    d = cnt[3];
            default:        d = '0;
        endcase
        return d;
    endfunction

    function automatic reg_data_t model_read(input reg_addr_t addr);
        return expected_read(model_enable, rd_status_valid, rd_status_tag,
                             wr_status_valid, wr_status_tag, model_cnt, addr);
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // one access that returns one ns after the response handshake
    task automatic reg_access(input logic wr, input reg_addr_t addr, input reg_data_t data);
        req.wr    = wr;
        req.addr  = addr;
        req.data  = data;
        req_valid = 1'b1;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        exp_q.push_back(wr ? '0 : model_read(addr));
        if (wr && {addr[15:2], 2'b00} == ADDR_ENABLE) begin
            model_enable = data[0];
        end
        #1;
        req_valid = 1'b0;
        @(posedge clk);
        while (!(rsp_valid && rsp_ready)) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic desc_check(input logic side_wr);
        dma_desc_t exp_d;
        reg_data_t len_word;
        reg_data_t tag_word;
        int        hold;
        int        issues_before;
        exp_d.pcie_addr  = {$urandom, $urandom};
        exp_d.local_addr = $urandom;
        len_word         = $urandom;
        tag_word         = $urandom;
        exp_d.len        = len_word[15:0];
        exp_d.tag        = tag_word[7:0];
        hold             = 1 + ($urandom % 8);
        issues_before    = side_wr ? wr_issues : rd_issues;
        reg_access(1'b1, side_wr ? ADDR_WR_PCIE_LO : ADDR_RD_PCIE_LO, exp_d.pcie_addr[31:0]);
        reg_access(1'b1, side_wr ? ADDR_WR_PCIE_HI : ADDR_RD_PCIE_HI, exp_d.pcie_addr[63:32]);
        reg_access(1'b1, side_wr ? ADDR_WR_LOCAL : ADDR_RD_LOCAL, exp_d.local_addr);
        reg_access(1'b1, side_wr ? ADDR_WR_LEN : ADDR_RD_LEN, len_word);
        check_value("desc valid before tag", 128'(side_wr ? wr_desc_valid : rd_desc_valid), 0);
        reg_access(1'b1, side_wr ? ADDR_WR_TAG : ADDR_RD_TAG, tag_word);
        // engine not ready yet
        for (int i = 0; i < hold; i++) begin
            check_value("desc valid", 128'(side_wr ? wr_desc_valid : rd_desc_valid), 1);
            check_value("desc fields", 128'(side_wr ? wr_desc : rd_desc), 128'(exp_d));
            @(posedge clk);
            #1;
        end
        if (side_wr) begin
            wr_desc_ready = 1'b1;
        end else begin
            rd_desc_ready = 1'b1;
        end
        @(posedge clk);
        #1;
        if (side_wr) begin
            wr_desc_ready = 1'b0;
        end else begin
            rd_desc_ready = 1'b0;
        end
        check_value("desc valid after handshake",
                    128'(side_wr ? wr_desc_valid : rd_desc_valid), 0);
        check_value("issues per tag write", 128'(side_wr ? wr_issues : rd_issues),
                    128'(issues_before + 1));
    endtask

    task automatic status_check(input logic side_wr);
        dma_tag_t  tag;
        reg_addr_t addr;
        int        pops_before;
        tag         = 8'($urandom);
        addr        = side_wr ? ADDR_WR_STATUS : ADDR_RD_STATUS;
        pops_before = side_wr ? wr_pops : rd_pops;
        if (side_wr) begin
            wr_status_tag   = tag;
            wr_status_valid = 1'b1;
        end else begin
            rd_status_tag   = tag;
            rd_status_valid = 1'b1;
        end
        @(posedge clk);
        #1;
        check_value("irq with status waiting", 128'(irq), 1);
        reg_access(1'b0, addr, '0);
        check_value("status pops", 128'(side_wr ? wr_pops : rd_pops), 128'(pops_before + 1));
        // engine drops the status after the pop
        if (side_wr) begin
            wr_status_valid = 1'b0;
            wr_status_tag   = '0;
        end else begin
            rd_status_valid = 1'b0;
            rd_status_tag   = '0;
        end
        reg_access(1'b0, addr, '0);
        check_value("status pops", 128'(side_wr ? wr_pops : rd_pops), 128'(pops_before + 1));
        check_value("irq after pop", 128'(irq), 0);
    endtask

    always @(posedge clk) begin
        if (!rst && rd_desc_valid && rd_desc_ready) begin
            rd_issues++;
        end
        if (!rst && wr_desc_valid && wr_desc_ready) begin
            wr_issues++;
        end
        if (rd_status_ready) begin
            rd_pops++;
        end
        if (wr_status_ready) begin
            wr_pops++;
        end
    end

    // response checker
    always @(posedge clk) begin
        if (!rst && rsp_valid && rsp_ready) begin
            assert (exp_q.size() != 0) else begin
                cmp_errors++;
                $display("response at %0t arrived with no request outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                cmp_checks++;
                cmp_exp = exp_q.pop_front();
                assert (rsp_data === cmp_exp) else begin
                    cmp_errors++;
                    $display("MISMATCH at %0t: response data %0h, expected %0h",
                             $time, rsp_data, cmp_exp);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        reg_data_t held;
        int        stall;
        void'($urandom(32'h4739));
        rst             = 1'b1;
        req             = '0;
        req_valid       = 1'b0;
        rsp_ready       = 1'b1;
        rd_desc_ready   = 1'b0;
        wr_desc_ready   = 1'b0;
        rd_status_tag   = '0;
        rd_status_valid = 1'b0;
        wr_status_tag   = '0;
        wr_status_valid = 1'b0;
        pkt_done        = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("outputs after reset", 128'({req_ready, rsp_valid, rd_desc_valid,
                    wr_desc_valid, rd_status_ready, wr_status_ready, dma_enable}), 128'(7'h40));

        // enable and unmapped addresses
        reg_access(1'b0, ADDR_ENABLE, '0);
        reg_access(1'b1, ADDR_ENABLE, 32'd1);
        check_value("dma_enable", 128'(dma_enable), 1);
        reg_access(1'b0, ADDR_ENABLE, '0);
        reg_access(1'b1, 16'h0004, 32'h0);
        reg_access(1'b1, 16'h0300, 32'hffff_ffff);
        reg_access(1'b0, 16'h0300, '0);
        reg_access(1'b0, 16'h011c, '0);
        reg_access(1'b0, ADDR_RD_LEN, '0);
        reg_access(1'b0, ADDR_ENABLE, '0);
        check_value("outputs after unmapped writes",
                    128'({dma_enable, rd_desc_valid, wr_desc_valid}), 128'(3'b100));

        desc_check(1'b0);
        rd_desc_ready = 1'b1;
        desc_check(1'b1);
        check_value("read issues while idle", 128'(rd_issues), 1);
        rd_desc_ready = 1'b0;

        status_check(1'b0);
        status_check(1'b1);

        for (int n = 0; n < 200; n++) begin
            pkt_done = 4'($urandom);
            for (int b = 0; b < 4; b++) begin
                if (pkt_done[b]) begin
                    model_cnt[b] = model_cnt[b] + 32'd1;
                end
            end
            @(posedge clk);
            #1;
        end
        pkt_done = '0;
        for (int i = 0; i < 4; i++) begin
            reg_access(1'b0, ADDR_CNT_RQ + 16'(4 * i), '0);
        end

        // host stalls the response while a write of enable 0 waits behind it
        rsp_ready = 1'b0;
        req.wr    = 1'b0;
        req.addr  = ADDR_ENABLE;
        req.data  = '0;
        req_valid = 1'b1;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        exp_q.push_back(model_read(ADDR_ENABLE));
        #1;
        req.wr = 1'b1;
        @(posedge clk);
        held  = rsp_data;
        stall = 2 + ($urandom % 8);
        for (int i = 0; i < stall; i++) begin
            check_value("req_ready during stall", 128'(req_ready), 0);
            check_value("rsp_data during stall", 128'(rsp_data), 128'(held));
            @(posedge clk);
        end
        #1;
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        @(posedge clk);
        #1;
        reg_access(1'b0, ADDR_ENABLE, '0);
        check_value("dma_enable after blocked write", 128'(dma_enable), 1);

        repeat (4) @(posedge clk);
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected responses never arrived", exp_q.size());
        end
        $display("checks %0d, response errors %0d, other errors %0d",
                 checks + cmp_checks, cmp_errors, errors);
        if (errors == 0 && cmp_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
logic/dma_ctrl_pkg.sv
logic/dma_reg_decode.sv
logic/dma_desc_issue.sv
logic/dma_reg_readback.sv
logic/pkt_counters.sv
logic/dma_ctrl_top.sv
dv/dma_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the register block testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    --top-module dma_ctrl_tb -f flist.f -o sim_dma_ctrl

./obj_dir/sim_dma_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
